// File: list.f
+incdir+rtl
rtl/bmu_pkg.sv
rtl/bmu_issue_stage.sv
rtl/bmu_b_decoder.sv
rtl/bmu_b_alu.sv
rtl/bmu_wb_stage.sv
rtl/bmu_top.sv
test/bmu_chk.sv
test/bmu_tb.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bmu_tb -f list.f -o bmu_sim
./obj_dir/bmu_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: test/bmu_tb.sv
// Testbench for bmu_top, runs directed and random Zba/Zbb/Zbs instructions against a queue model
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_tb import bmu_pkg::*; ();

  localparam int num_dir    = 24 * 5 + 5 * 3 + 2 + 6;    // Edge sweep, immediates, rori edges, illegal
  localparam int num_rand   = 260;
  localparam int max_cycles = 5 * (num_dir + num_rand);  // At most 2 cycles each, plus margin

  logic                      clk;
  logic                      arst_n_i;
  logic                      valid_i;
  logic [31:0]               instr_i;
  logic [`BMU_XLEN-1:0]      rs1_i;
  logic [`BMU_XLEN-1:0]      rs2_i;
  logic                      valid_o;
  logic [`BMU_XLEN-1:0]      result_o;
  logic [`BMU_REG_IDX_W-1:0] rd_o;
  logic                      illegal_o;

  int          seed   = 48;
  int          cycles = 0;
  string       name_q[$];  // Test name per instruction in flight
  logic [37:0] exp_q[$];   // {illegal, rd, result}, oldest first
  logic [31:0] edge_val[5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1};
  alu_op_e     imm_ops[5]  = '{ALU_B_ROR, ALU_B_BSET, ALU_B_BCLR, ALU_B_BINV, ALU_B_BEXT};

  // {funct7, rs2 field, funct3} of each operation in alu_op_e order
  logic [14:0] enc_tab[25] = '{15'h0,
    {7'b0010000, 5'b00000, 3'b010}, {7'b0010000, 5'b00000, 3'b100}, {7'b0010000, 5'b00000, 3'b110},
    {7'b0000101, 5'b00000, 3'b100}, {7'b0000101, 5'b00000, 3'b101}, {7'b0000101, 5'b00000, 3'b110},
    {7'b0000101, 5'b00000, 3'b111}, {7'b0100000, 5'b00000, 3'b111}, {7'b0100000, 5'b00000, 3'b110},
    {7'b0100000, 5'b00000, 3'b100}, {7'b0110000, 5'b00000, 3'b001}, {7'b0110000, 5'b00000, 3'b101},
    {7'b0000100, 5'b00000, 3'b100}, {7'b0110000, 5'b00100, 3'b001}, {7'b0110000, 5'b00101, 3'b001},
    {7'b0110000, 5'b00000, 3'b001}, {7'b0110000, 5'b00001, 3'b001}, {7'b0110000, 5'b00010, 3'b001},
    {7'b0010100, 5'b00111, 3'b101}, {7'b0110100, 5'b11000, 3'b101}, {7'b0010100, 5'b00000, 3'b001},
    {7'b0100100, 5'b00000, 3'b001}, {7'b0110100, 5'b00000, 3'b001}, {7'b0100100, 5'b00000, 3'b101}};

  bmu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] encode_instr(input alu_op_e op, input logic imm,
                                               input logic [4:0] shamt, input logic [4:0] rd);
    logic [14:0] e;
    opcode_e     opc;
    e   = enc_tab[op];
    opc = OPCODE_OP;
    if (imm || (op inside {[ALU_B_SEXT_B:ALU_B_REV8]})) opc = OPCODE_OPIMM;  // Unary lives in OP-IMM
    return {e[14:8], imm ? shamt : e[7:3], 5'd1, e[2:0], rd, opc};
  endfunction

  // Expected result from the instruction definitions, b already holds the shamt for immediates
  function automatic logic [31:0] ref_result(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] r;
    int          n;
    int          i;
    r = '0;
    n = {27'd0, b[4:0]};
    case (op)
      ALU_B_SH1ADD: r = b + {a[30:0], 1'b0};
      ALU_B_SH2ADD: r = b + {a[29:0], 2'b00};
      ALU_B_SH3ADD: r = b + {a[28:0], 3'b000};
      ALU_B_MIN:    r = ($signed(a) <= $signed(b)) ? a : b;
      ALU_B_MINU:   r = (a <= b) ? a : b;
      ALU_B_MAX:    r = ($signed(a) >= $signed(b)) ? a : b;
      ALU_B_MAXU:   r = (a >= b) ? a : b;
      ALU_B_ANDN:   r = a & ~b;
      ALU_B_ORN:    r = a | ~b;
      ALU_B_XNOR:   r = a ~^ b;
      ALU_B_ROL:    r = (a << n) | (a >> (32 - n));  // Shift by 32 gives zero
      ALU_B_ROR:    r = (a >> n) | (a << (32 - n));
      ALU_B_ZEXT_H: r = {16'h0000, a[15:0]};
      ALU_B_SEXT_B: r = {{24{a[7]}}, a[7:0]};
      ALU_B_SEXT_H: r = {{16{a[15]}}, a[15:0]};
      ALU_B_CLZ:    for (i = 31; i >= 0 && !a[i]; i--) r++;
      ALU_B_CTZ:    for (i = 0; i < 32 && !a[i]; i++) r++;
      ALU_B_CPOP:   for (i = 0; i < 32; i++) r = r + {31'd0, a[i]};
      ALU_B_ORC_B:  for (i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
      ALU_B_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      ALU_B_BSET:   r = a | (32'd1 << n);
      ALU_B_BCLR:   r = a & ~(32'd1 << n);
      ALU_B_BINV:   r = a ^ (32'd1 << n);
      ALU_B_BEXT:   r = (a >> n) & 32'd1;
      default:      r = '0;
    endcase
    return r;
  endfunction

  // One issue cycle plus its expected response
  task automatic push_instr(input string name, input logic [31:0] ins, input logic [31:0] a,
                            input logic [31:0] b, input logic ill, input logic [31:0] res);
    @(posedge clk);
    valid_i <= 1'b1;
    instr_i <= ins;
    rs1_i   <= a;
    rs2_i   <= b;
    name_q.push_back(name);
    exp_q.push_back({ill, ins[11:7], ill ? 32'd0 : res});  // Illegal writes back zero
  endtask

  task automatic insert_bubble();
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  task automatic send_op(input string name, input alu_op_e op, input logic imm_form,
                         input logic [31:0] a, input logic [31:0] b);
    logic        imm;
    logic        ill;
    logic [31:0] rnd;
    imm = imm_form && (op inside {ALU_B_ROR, ALU_B_BSET, ALU_B_BCLR, ALU_B_BINV, ALU_B_BEXT});
    ill = (op inside {[ALU_B_SH1ADD:ALU_B_SH3ADD]}) ? (`BMU_ZBA_EN == 0) :
          (op inside {[ALU_B_BSET:ALU_B_BEXT]})     ? (`BMU_ZBS_EN == 0) : (`BMU_ZBB_EN == 0);
    rnd = $random(seed);
    push_instr(name, encode_instr(op, imm, b[4:0], rnd[11:7]), a, imm ? rnd : b, ill,
               ref_result(op, a, imm ? {27'd0, b[4:0]} : b));
  endtask

  task automatic send_illegal(input string name, input logic [31:0] ins);
    logic [31:0] rnd;
    rnd = $random(seed);
    push_instr(name, ins, rnd, ~rnd, 1'b1, 32'd0);
  endtask

  initial begin
    alu_op_e     op;
    logic [31:0] rnd;
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    instr_i  = '0;
    rs1_i    = '0;
    rs2_i    = '0;
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;

    ////////////////////////////////////////
    // Directed
    ////////////////////////////////////////
    op = ALU_B_SH1ADD;
    repeat (24) begin  // All register and unary forms on edge pairs
      for (int j = 0; j < 5; j++) send_op($sformatf("edge_%s", op.name()), op, 1'b0,
                                          edge_val[j], edge_val[(j + 1) % 5]);
      op = op.next();
    end
    foreach (imm_ops[k]) begin  // Immediate index 0, 31 and random
      rnd = $random(seed);
      send_op($sformatf("imm_%s", imm_ops[k].name()), imm_ops[k], 1'b1, rnd, 32'd0);
      send_op($sformatf("imm_%s", imm_ops[k].name()), imm_ops[k], 1'b1, ~rnd, 32'd31);
      send_op($sformatf("imm_%s", imm_ops[k].name()), imm_ops[k], 1'b1, rnd, rnd >> 16);
    end
    send_op("imm_rori_zero", ALU_B_ROR, 1'b1, 32'h0000_0000, rnd);  // Rotate of 0 stays 0
    send_op("imm_rori_ones", ALU_B_ROR, 1'b1, 32'hffff_ffff, ~rnd);
    insert_bubble();
    send_illegal("zext_h_rs2", {7'b0000100, 5'd3, 5'd1, 3'b100, 5'd9, OPCODE_OP});
    send_illegal("bad_funct7", {7'b1111111, 5'd2, 5'd1, 3'b001, 5'd10, OPCODE_OP});
    send_illegal("bad_funct3", {7'b0010000, 5'd2, 5'd1, 3'b000, 5'd11, OPCODE_OP});
    send_illegal("bad_unary", {7'b0110000, 5'd3, 5'd1, 3'b001, 5'd12, OPCODE_OPIMM});
    send_illegal("load_opcode", {7'b0110000, 5'd0, 5'd1, 3'b001, 5'd13, 7'b0000011});
    send_illegal("lui_opcode", {20'h12345, 5'd31, 7'b0110111});

    ////////////////////////////////////////
    // Random mix with bubbles
    ////////////////////////////////////////
    for (int n = 0; n < num_rand; n++) begin
      rnd = $random(seed);
      op  = ALU_B_SH1ADD;
      repeat (rnd[7:0] % 24) op = op.next();
      if (rnd[10:8] == 3'd0) begin
        send_illegal("rand_illegal", {7'b1111111, rnd[31:7]});  // No B op uses this funct7
      end else begin
        send_op($sformatf("rand_%s", op.name()), op, rnd[11], $random(seed), $random(seed));
      end
      if (rnd[13:12] == 2'd0) insert_bubble();
    end
    insert_bubble();
    repeat (4) @(posedge clk);  // Last pulse lands two edges on, two more to see it drop
    if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("Not every instruction came back two cycles after issue");
    end
  end

  // Scoreboard, outputs sampled mid-cycle
  always @(negedge clk) begin
    string       nm;
    logic [37:0] exp;
    if (arst_n_i && valid_o) begin
      assert (exp_q.size() != 0) else fail_run("valid_o pulsed with no instruction in flight");
      nm  = name_q.pop_front();
      exp = exp_q.pop_front();
      assert ({illegal_o, rd_o, result_o} == exp)
        else fail_run($sformatf("ERROR %s illegal/rd/result: expected %h, actual %h",
                                nm, exp, {illegal_o, rd_o, result_o}));
    end
    assert (dut.chk.err_cnt == 0) else fail_run("A bound protocol assertion in bmu_chk failed");
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) fail_run("Timeout, the DUT did not return every instruction");
  end

endmodule

// File: test/bmu_chk.sv
// Protocol checker bound into bmu_top, watches latency, zero result on illegal and reset quiet
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_chk (
  input logic                 clk,
  input logic                 arst_n_i,
  input logic                 valid_i,
  input logic                 valid_o,
  input logic [`BMU_XLEN-1:0] result_o,
  input logic                 illegal_o
);

  int unsigned err_cnt = 0;  // Failures so far

  // Fixed 2-cycle latency, no lost or extra pulses
  latency_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_o == $past(valid_i, 2))
    else begin
      err_cnt++;
      $error("valid_o is not valid_i delayed by two cycles");
    end

  illegal_zero_a: assert property (@(posedge clk) illegal_o |-> result_o == '0)
    else begin
      err_cnt++;
      $error("result_o nonzero while illegal_o is high");
    end

  reset_quiet_a: assert property (@(posedge clk) !arst_n_i |-> !valid_o)
    else begin
      err_cnt++;
      $error("valid_o high during reset");
    end

endmodule

bind bmu_top bmu_chk chk (
  .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .valid_o(valid_o),
  .result_o(result_o), .illegal_o(illegal_o)
);

// File: rtl/bmu_top.sv
// Top of the bit-manipulation slice: issue register, decoder, ALU and writeback register, 2-cycle latency
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_top import bmu_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  logic [31:0]               instr_i,
  input  logic [`BMU_XLEN-1:0]      rs1_i,
  input  logic [`BMU_XLEN-1:0]      rs2_i,
  output logic                      valid_o,
  output logic [`BMU_XLEN-1:0]      result_o,
  output logic [`BMU_REG_IDX_W-1:0] rd_o,
  output logic                      illegal_o
);

  logic                 iss_valid;
  logic [31:0]          iss_instr;
  logic [`BMU_XLEN-1:0] iss_rs1;
  logic [`BMU_XLEN-1:0] iss_rs2;
  alu_op_e              dec_op;
  op_b_sel_e            dec_op_b_sel;
  logic                 dec_illegal;
  logic [`BMU_XLEN-1:0] alu_result;

  bmu_issue_stage u_issue (  // Cycle 1
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .instr_i(instr_i),
    .rs1_i(rs1_i), .rs2_i(rs2_i), .valid_o(iss_valid), .instr_o(iss_instr),
    .rs1_o(iss_rs1), .rs2_o(iss_rs2)
  );

  bmu_b_decoder u_dec (
    .instr_i(iss_instr), .op_o(dec_op), .op_b_sel_o(dec_op_b_sel), .illegal_o(dec_illegal)
  );

  bmu_b_alu u_alu (
    .op_i(dec_op), .op_b_sel_i(dec_op_b_sel), .rs1_i(iss_rs1), .rs2_i(iss_rs2),
    .shamt_i(iss_instr[24:20]), .result_o(alu_result)
  );

  bmu_wb_stage u_wb (  // Cycle 2, rd from instr[11:7]
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(iss_valid), .result_i(alu_result),
    .rd_i(iss_instr[11:7]), .illegal_i(dec_illegal), .valid_o(valid_o),
    .result_o(result_o), .rd_o(rd_o), .illegal_o(illegal_o)
  );

endmodule

// File: rtl/bmu_wb_stage.sv
// Output register of the bit-manipulation slice, holds result, rd and illegal flag with the valid pulse
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_wb_stage (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,    // Issue stage holds an instruction
  input  logic [`BMU_XLEN-1:0]      result_i,
  input  logic [`BMU_REG_IDX_W-1:0] rd_i,
  input  logic                      illegal_i,
  output logic                      valid_o,    // One-cycle writeback pulse
  output logic [`BMU_XLEN-1:0]      result_o,
  output logic [`BMU_REG_IDX_W-1:0] rd_o,
  output logic                      illegal_o
);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;  // Pulse follows issue valid
    end
  end

  // Writeback payload, loaded only for real instructions
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o  <= '0;
      rd_o      <= '0;
      illegal_o <= 1'b0;
    end else if (valid_i) begin
      result_o  <= illegal_i ? '0 : result_i;  // Illegal never writes data
      rd_o      <= rd_i;
      illegal_o <= illegal_i;
    end
  end

endmodule

// File: rtl/bmu_b_alu.sv
// Combinational Zba/Zbb/Zbs execution unit, driven by the decoder operation and issue-stage operands
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_b_alu import bmu_pkg::*; (
  input  alu_op_e              op_i,
  input  op_b_sel_e            op_b_sel_i,
  input  logic [`BMU_XLEN-1:0] rs1_i,
  input  logic [`BMU_XLEN-1:0] rs2_i,
  input  logic [4:0]           shamt_i,   // Instruction bits 24:20
  output logic [`BMU_XLEN-1:0] result_o
);

  localparam int xlen  = `BMU_XLEN;
  localparam int idx_w = $clog2(xlen);
  localparam int cnt_w = idx_w + 1;   // Counts reach xlen

  logic [xlen-1:0]   op_b;
  logic [idx_w-1:0]  idx;        // Bit / rotate index
  logic [xlen-1:0]   bit_mask;   // One-hot at idx
  logic [2*xlen-1:0] rot_l;      // Doubled word, shifted left
  logic [2*xlen-1:0] rot_r;      // Doubled word, shifted right
  logic              lt_s;
  logic              lt_u;
  logic [cnt_w-1:0]  clz_cnt;
  logic [cnt_w-1:0]  ctz_cnt;
  logic [cnt_w-1:0]  cpop_cnt;
  logic              lead_done;  // First one seen from MSB
  logic              trail_done; // First one seen from LSB
  logic [xlen-1:0]   orc_b;
  logic [xlen-1:0]   rev8;

  assign op_b     = (op_b_sel_i == OP_B_IMM) ? {{(xlen-5){1'b0}}, shamt_i} : rs2_i;
  assign idx      = op_b[idx_w-1:0];
  assign bit_mask = {{(xlen-1){1'b0}}, 1'b1} << idx;
  assign rot_l    = {rs1_i, rs1_i} << idx;
  assign rot_r    = {rs1_i, rs1_i} >> idx;
  assign lt_s     = $signed(rs1_i) < $signed(op_b);
  assign lt_u     = rs1_i < op_b;

  ////////////////////////////////////////
  // Counts and byte operations
  ////////////////////////////////////////
  always_comb begin
    clz_cnt    = '0;
    ctz_cnt    = '0;
    cpop_cnt   = '0;
    lead_done  = 1'b0;
    trail_done = 1'b0;
    for (int i = xlen - 1; i >= 0; i--) begin  // Scan down for clz
      if (rs1_i[i]) lead_done = 1'b1;
      else if (!lead_done) clz_cnt = clz_cnt + 1'b1;
    end
    for (int i = 0; i < xlen; i++) begin  // Scan up for ctz and cpop
      if (rs1_i[i]) trail_done = 1'b1;
      else if (!trail_done) ctz_cnt = ctz_cnt + 1'b1;
      cpop_cnt = cpop_cnt + {{(cnt_w-1){1'b0}}, rs1_i[i]};
    end
    for (int b = 0; b < xlen / 8; b++) begin
      orc_b[8*b +: 8] = {8{|rs1_i[8*b +: 8]}};    // Any bit set fills the byte
      rev8[8*b +: 8]  = rs1_i[xlen-8-8*b +: 8];  // Byte swap
    end
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    unique case (op_i)
      ALU_B_SH1ADD: result_o = (rs1_i << 1) + op_b;
      ALU_B_SH2ADD: result_o = (rs1_i << 2) + op_b;
      ALU_B_SH3ADD: result_o = (rs1_i << 3) + op_b;
      ALU_B_MIN:    result_o = lt_s ? rs1_i : op_b;
      ALU_B_MINU:   result_o = lt_u ? rs1_i : op_b;
      ALU_B_MAX:    result_o = lt_s ? op_b : rs1_i;
      ALU_B_MAXU:   result_o = lt_u ? op_b : rs1_i;
      ALU_B_ANDN:   result_o = rs1_i & ~op_b;
      ALU_B_ORN:    result_o = rs1_i | ~op_b;
      ALU_B_XNOR:   result_o = ~(rs1_i ^ op_b);
      ALU_B_ROL:    result_o = rot_l[2*xlen-1:xlen];  // Upper half holds wrapped bits
      ALU_B_ROR:    result_o = rot_r[xlen-1:0];
      ALU_B_ZEXT_H: result_o = {{(xlen-16){1'b0}}, rs1_i[15:0]};
      ALU_B_SEXT_B: result_o = {{(xlen-8){rs1_i[7]}}, rs1_i[7:0]};
      ALU_B_SEXT_H: result_o = {{(xlen-16){rs1_i[15]}}, rs1_i[15:0]};
      ALU_B_CLZ:    result_o = {{(xlen-cnt_w){1'b0}}, clz_cnt};
      ALU_B_CTZ:    result_o = {{(xlen-cnt_w){1'b0}}, ctz_cnt};
      ALU_B_CPOP:   result_o = {{(xlen-cnt_w){1'b0}}, cpop_cnt};
      ALU_B_ORC_B:  result_o = orc_b;
      ALU_B_REV8:   result_o = rev8;
      ALU_B_BSET:   result_o = rs1_i | bit_mask;
      ALU_B_BCLR:   result_o = rs1_i & ~bit_mask;
      ALU_B_BINV:   result_o = rs1_i ^ bit_mask;
      ALU_B_BEXT:   result_o = {{(xlen-1){1'b0}}, rs1_i[idx]};
      default:      result_o = '0;  // ALU_NOP
    endcase
  end

endmodule

// File: rtl/bmu_b_decoder.sv
// Combinational Zba/Zbb/Zbs decoder, maps an instruction word to ALU operation, operand B and illegal
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_b_decoder import bmu_pkg::*; (
  input  logic [31:0] instr_i,
  output alu_op_e     op_o,
  output op_b_sel_e   op_b_sel_o,
  output logic        illegal_o
);

  localparam bit zba_en = `BMU_ZBA_EN;
  localparam bit zbb_en = `BMU_ZBB_EN;
  localparam bit zbs_en = `BMU_ZBS_EN;

  logic [6:0] funct7;
  logic [4:0] rs2_f;   // rs2 field, shamt for immediate forms
  logic [2:0] funct3;

  alu_op_e    cand_op;   // Matched operation
  op_b_sel_e  cand_sel;  // Matched operand B source
  logic       cand_en;   // Match found and its group enabled

  assign funct7 = instr_i[31:25];
  assign rs2_f  = instr_i[24:20];
  assign funct3 = instr_i[14:12];

  ////////////////////////////////////////
  // Pattern match
  ////////////////////////////////////////
  always_comb begin
    cand_op  = ALU_NOP;
    cand_sel = OP_B_REG;
    cand_en  = 1'b0;

    unique case (instr_i[6:0])
      OPCODE_OP: begin
        unique case ({funct7, funct3})
          // Zba
          {7'b0010000, 3'b010}: begin cand_op = ALU_B_SH1ADD; cand_en = zba_en; end
          {7'b0010000, 3'b100}: begin cand_op = ALU_B_SH2ADD; cand_en = zba_en; end
          {7'b0010000, 3'b110}: begin cand_op = ALU_B_SH3ADD; cand_en = zba_en; end
          // Zbb min/max
          {7'b0000101, 3'b100}: begin cand_op = ALU_B_MIN;  cand_en = zbb_en; end
          {7'b0000101, 3'b101}: begin cand_op = ALU_B_MINU; cand_en = zbb_en; end
          {7'b0000101, 3'b110}: begin cand_op = ALU_B_MAX;  cand_en = zbb_en; end
          {7'b0000101, 3'b111}: begin cand_op = ALU_B_MAXU; cand_en = zbb_en; end
          // Zbb logic with negate
          {7'b0100000, 3'b111}: begin cand_op = ALU_B_ANDN; cand_en = zbb_en; end
          {7'b0100000, 3'b110}: begin cand_op = ALU_B_ORN;  cand_en = zbb_en; end
          {7'b0100000, 3'b100}: begin cand_op = ALU_B_XNOR; cand_en = zbb_en; end
          // Zbb rotates by register
          {7'b0110000, 3'b001}: begin cand_op = ALU_B_ROL; cand_en = zbb_en; end
          {7'b0110000, 3'b101}: begin cand_op = ALU_B_ROR; cand_en = zbb_en; end
          {7'b0000100, 3'b100}: begin
            cand_op = ALU_B_ZEXT_H;
            cand_en = zbb_en && (rs2_f == 5'b00000);  // rs2 field hardwired to x0
          end
          // Zbs by register
          {7'b0010100, 3'b001}: begin cand_op = ALU_B_BSET; cand_en = zbs_en; end
          {7'b0100100, 3'b001}: begin cand_op = ALU_B_BCLR; cand_en = zbs_en; end
          {7'b0110100, 3'b001}: begin cand_op = ALU_B_BINV; cand_en = zbs_en; end
          {7'b0100100, 3'b101}: begin cand_op = ALU_B_BEXT; cand_en = zbs_en; end
          default: begin
            cand_en = 1'b0;  // Unknown funct7/funct3
          end
        endcase
      end

      OPCODE_OPIMM: begin
        unique casez ({funct7, rs2_f, funct3})
          // Zbb unary, rs2 field selects the function
          {7'b0110000, 5'b00000, 3'b001}: begin cand_op = ALU_B_CLZ;    cand_en = zbb_en; end
          {7'b0110000, 5'b00001, 3'b001}: begin cand_op = ALU_B_CTZ;    cand_en = zbb_en; end
          {7'b0110000, 5'b00010, 3'b001}: begin cand_op = ALU_B_CPOP;   cand_en = zbb_en; end
          {7'b0110000, 5'b00100, 3'b001}: begin cand_op = ALU_B_SEXT_B; cand_en = zbb_en; end
          {7'b0110000, 5'b00101, 3'b001}: begin cand_op = ALU_B_SEXT_H; cand_en = zbb_en; end
          {7'b0010100, 5'b00111, 3'b101}: begin cand_op = ALU_B_ORC_B;  cand_en = zbb_en; end
          {7'b0110100, 5'b11000, 3'b101}: begin cand_op = ALU_B_REV8;   cand_en = zbb_en; end
          // Immediate forms, shamt in rs2 field
          {7'b0110000, 5'b?????, 3'b101}: begin  // rori
            cand_op  = ALU_B_ROR;
            cand_sel = OP_B_IMM;
            cand_en  = zbb_en;
          end
          {7'b0010100, 5'b?????, 3'b001}: begin  // bseti
            cand_op  = ALU_B_BSET;
            cand_sel = OP_B_IMM;
            cand_en  = zbs_en;
          end
          {7'b0100100, 5'b?????, 3'b001}: begin  // bclri
            cand_op  = ALU_B_BCLR;
            cand_sel = OP_B_IMM;
            cand_en  = zbs_en;
          end
          {7'b0110100, 5'b?????, 3'b001}: begin  // binvi
            cand_op  = ALU_B_BINV;
            cand_sel = OP_B_IMM;
            cand_en  = zbs_en;
          end
          {7'b0100100, 5'b?????, 3'b101}: begin  // bexti
            cand_op  = ALU_B_BEXT;
            cand_sel = OP_B_IMM;
            cand_en  = zbs_en;
          end
          default: begin
            cand_en = 1'b0;  // Not a B-extension immediate op
          end
        endcase
      end

      default: begin
        cand_en = 1'b0;  // Other major opcodes are not ours
      end
    endcase
  end

  ////////////////////////////////////////
  // Gate by group enable
  ////////////////////////////////////////
  always_comb begin
    illegal_o  = !cand_en;
    op_o       = ALU_NOP;   // Illegal decodes to NOP
    op_b_sel_o = OP_B_REG;
    if (cand_en) begin
      op_o       = cand_op;
      op_b_sel_o = cand_sel;
    end
  end

endmodule

// File: rtl/bmu_issue_stage.sv
// Input pipeline register of the bit-manipulation slice, captures instruction and operands on valid_i
`timescale 1ns/1ns
`include "bmu_cfg.svh"

module bmu_issue_stage (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 valid_i,   // One-cycle issue strobe
  input  logic [31:0]          instr_i,
  input  logic [`BMU_XLEN-1:0] rs1_i,
  input  logic [`BMU_XLEN-1:0] rs2_i,
  output logic                 valid_o,   // Instruction held in this stage
  output logic [31:0]          instr_o,
  output logic [`BMU_XLEN-1:0] rs1_o,
  output logic [`BMU_XLEN-1:0] rs2_o
);

  // Valid flag tracks the strobe every cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves on a real issue, bubbles keep it still
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_o <= '0;
      rs1_o   <= '0;
      rs2_o   <= '0;
    end else if (valid_i) begin
      instr_o <= instr_i;
      rs1_o   <= rs1_i;  // Source 1
      rs2_o   <= rs2_i;  // Source 2
    end
  end

endmodule

// File: rtl/bmu_pkg.sv
// Shared types for the bit-manipulation slice, imported by the decoder, ALU and testbench
package bmu_pkg;

  // Major opcodes handled by the slice
  typedef enum logic [6:0] {
    OPCODE_OP    = 7'b0110011,  // Register-register
    OPCODE_OPIMM = 7'b0010011   // Register-immediate
  } opcode_e;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////
  typedef enum logic [4:0] {
    ALU_NOP,        // Illegal or idle, result zero
    // Zba
    ALU_B_SH1ADD,
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    // Zbb compare
    ALU_B_MIN,
    ALU_B_MINU,
    ALU_B_MAX,
    ALU_B_MAXU,
    // Zbb logic with inverted operand
    ALU_B_ANDN,
    ALU_B_ORN,
    ALU_B_XNOR,
    // Zbb rotates
    ALU_B_ROL,
    ALU_B_ROR,
    // Zbb extension
    ALU_B_ZEXT_H,
    ALU_B_SEXT_B,
    ALU_B_SEXT_H,
    // Zbb counts
    ALU_B_CLZ,
    ALU_B_CTZ,
    ALU_B_CPOP,
    // Zbb byte ops
    ALU_B_ORC_B,
    ALU_B_REV8,
    // Zbs
    ALU_B_BSET,
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT
  } alu_op_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG = 1'b0,  // rs2 value
    OP_B_IMM = 1'b1   // Instruction bits 24:20
  } op_b_sel_e;

endpackage

// File: rtl/bmu_cfg.svh
// Bit-manipulation slice configuration: group enables and widths, include where the macros are used
`ifndef BMU_CFG_SVH
`define BMU_CFG_SVH

////////////////////////////////////////
// Instruction group enables (1 or 0)
////////////////////////////////////////
`define BMU_ZBA_EN 1  // Address generation (shNadd)
`define BMU_ZBB_EN 1  // Basic bit manipulation
`define BMU_ZBS_EN 1  // Single-bit operations

// Widths
`define BMU_XLEN     32  // Data path width
`define BMU_REG_IDX_W 5  // Register index width

`endif
